//--- sim.f
verilog/bram_pkg.sv
verilog/ram_half.sv
verilog/fifo_ctl.sv
verilog/port_steer.sv
verilog/read_steer.sv
verilog/tdp36k.sv
dv/tb_tdp36k.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_tdp36k
out=$(./obj_dir/Vtb_tdp36k)
echo "$out"
echo "$out" | grep -q "Test completed successfully"

//--- dv/tb_tdp36k.sv
`timescale 1ns/1ps

module tb_tdp36k;
   import bram_pkg::*;

   localparam int AE_LEVEL = 4;   // fifo thresholds
   localparam int AF_LEVEL = 4;
   // cycle budgets of split, wide, narrow, fifo and flag tests
   localparam int BUDGET   = 150 + 100 + 200 + 600 + 4300;

   logic               sclk_a1 = 1'b0;
   logic               sresetn;
   logic               split_i, fmode_i, flush_i;
   logic [2:0]         wmode_a1_i, rmode_b1_i;
   logic               wen_a1_i, wen_a2_i, ren_b1_i, ren_b2_i;
   logic [1:0]         be_a1_i, be_a2_i;
   logic [COMB_AW-1:0] addr_a1_i, addr_b1_i;
   logic [HALF_AW-1:0] addr_a2_i, addr_b2_i;
   logic [HALF_DW-1:0] wdata_a1_i, wdata_a2_i, rdata_b1_o, rdata_b2_o;
   logic [FIFO_AW-1:0] upae_i, upaf_i;

   logic [HALF_DW-1:0] mem_h1 [0:2**HALF_AW-1];   // reference halves
   logic [HALF_DW-1:0] mem_h2 [0:2**HALF_AW-1];
   logic [HALF_DW-1:0] fifo_q [$];
   logic [HALF_DW-1:0] last_data = '0;           // last word popped
   logic               ur_flag, ovr_flag;
   logic [HALF_AW-1:0] words [0:15];             // addresses in use
   integer             seed = 32'h7a97;
   int                 checks = 0, errors = 0, tests = 0;

   tdp36k u_dut (.*);

   always #5 sclk_a1 = ~sclk_a1;

   task automatic compare(input logic [HALF_DW-1:0] actual, input logic [HALF_DW-1:0] expected,
                          input string msg);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
      end
   endtask

   task automatic report_test(input string name, input int err0);
      tests++;
      $display("%s: %s (%0d errors)", name, (errors == err0) ? "ok" : "FAILED", errors - err0);
   endtask

   function automatic logic [HALF_DW-1:0] merge_lanes(input logic [HALF_DW-1:0] old,
         input logic [1:0] be, input logic [HALF_DW-1:0] data);
      logic [HALF_DW-1:0] res;
      res = old;
      if (be[0]) begin
         res[LANE_DW-1:0] = data[LANE_DW-1:0];
      end
      if (be[1]) begin
         res[HALF_DW-1:LANE_DW] = data[HALF_DW-1:LANE_DW];
      end
      return res;
   endfunction

   // status word from the model count, thresholds and sticky flags
   function automatic logic [HALF_DW-1:0] expected_flags();
      int cnt;
      cnt = fifo_q.size();
      return {12'b0, cnt == 0, cnt <= AE_LEVEL, ur_flag, cnt == FIFO_DEPTH,
              cnt >= FIFO_DEPTH - AF_LEVEL, ovr_flag};
   endfunction

   task automatic check_flags(input string msg);
      compare(rdata_b2_o, expected_flags(), msg);
   endtask

   task automatic set_mode(input logic split, input logic fmode);
      @(posedge sclk_a1);
      split_i <= split;
      fmode_i <= fmode;
   endtask

   // one write cycle, back to back until end_write
   task automatic drive_write(input logic [2:0] wmode, input logic [COMB_AW-1:0] a1,
         input logic [1:0] be1, input logic [HALF_DW-1:0] d1, input logic [HALF_AW-1:0] a2,
         input logic [1:0] be2, input logic [HALF_DW-1:0] d2);
      @(posedge sclk_a1);
      wmode_a1_i <= wmode;
      {wen_a1_i, wen_a2_i} <= 2'b11;   // A2 is ignored outside split mode
      {addr_a1_i, be_a1_i, wdata_a1_i} <= {a1, be1, d1};
      {addr_a2_i, be_a2_i, wdata_a2_i} <= {a2, be2, d2};
   endtask

   task automatic end_write();
      @(posedge sclk_a1);
      {wen_a1_i, wen_a2_i} <= 2'b00;
   endtask

   // read data is checked after the sampling edge
   task automatic drive_read(input logic [2:0] rmode, input logic [COMB_AW-1:0] a1,
         input logic [HALF_AW-1:0] a2);
      @(posedge sclk_a1);
      rmode_b1_i <= rmode;
      {ren_b1_i, ren_b2_i} <= 2'b11;
      {addr_b1_i, addr_b2_i} <= {a1, a2};
      @(posedge sclk_a1);
      {ren_b1_i, ren_b2_i} <= 2'b00;
      @(negedge sclk_a1);
   endtask

   task automatic push_burst(input int n);
      logic [31:0] rnd;
      for (int i = 0; i < n; i++) begin
         rnd = $random(seed);
         @(posedge sclk_a1);
         wen_a1_i   <= 1'b1;
         wdata_a1_i <= rnd[17:0];
         if (fifo_q.size() < FIFO_DEPTH) begin
            fifo_q.push_back(rnd[17:0]);
         end else begin
            ovr_flag = 1'b1;   // word is dropped
         end
      end
      @(posedge sclk_a1);
      wen_a1_i <= 1'b0;
      @(negedge sclk_a1);
   endtask

   task automatic pop_burst(input int n);
      if (n > 0) begin
         @(posedge sclk_a1);
         ren_b1_i <= 1'b1;
         for (int i = 0; i < n; i++) begin
            @(posedge sclk_a1);
            if (i == n - 1) begin
               ren_b1_i <= 1'b0;
            end
            if (fifo_q.size() > 0) begin
               last_data = fifo_q.pop_front();
            end else begin
               ur_flag = 1'b1;   // output keeps the old word
            end
            @(negedge sclk_a1);
            compare(rdata_b1_o, last_data, $sformatf("fifo pop %0d of %0d", i, n));
         end
      end
   endtask

   task automatic flush_fifo();
      @(posedge sclk_a1);
      flush_i <= 1'b1;
      @(posedge sclk_a1);
      flush_i <= 1'b0;
      @(negedge sclk_a1);
      fifo_q.delete();
      {ur_flag, ovr_flag} = 2'b00;
   endtask

   task automatic test_split();
      logic [31:0]        rnd, rnd2;
      logic [HALF_AW-1:0] a, b;
      logic [1:0]         be1, be2;
      int                 err0;
      err0 = errors;
      compare(rdata_b1_o, '0, "B1 after reset");
      compare(rdata_b2_o, '0, "B2 after reset");
      for (int i = 0; i < 16; i++) begin
         words[i] = HALF_AW'(i * 37 + 5);
      end
      for (int i = 0; i < 32; i++) begin
         rnd  = $random(seed);
         rnd2 = $random(seed);
         if (i < 16) begin
            {a, b, be1, be2} = {words[i], words[15 - i], 4'b1111};   // full words first
         end else begin
            {a, b, be1, be2} = {words[rnd[23:20]], words[rnd2[23:20]], rnd[19:18], rnd2[19:18]};
         end
         drive_write(MODE_36, {2'b00, a}, be1, rnd[17:0], b, be2, rnd2[17:0]);
         mem_h1[a] = merge_lanes(mem_h1[a], be1, rnd[17:0]);
         mem_h2[b] = merge_lanes(mem_h2[b], be2, rnd2[17:0]);
      end
      end_write();
      for (int i = 0; i < 16; i++) begin
         drive_read(MODE_36, {2'b00, words[i]}, words[(i + 3) % 16]);
         compare(rdata_b1_o, mem_h1[words[i]], $sformatf("split B1 word %0d", words[i]));
         compare(rdata_b2_o, mem_h2[words[(i + 3) % 16]], "split B2 word");
      end
      report_test("split mode", err0);
   endtask

   task automatic test_wide();
      logic [31:0]        rnd, rnd2;
      logic [HALF_AW-1:0] w;
      int                 err0;
      err0 = errors;
      set_mode(1'b0, 1'b0);
      for (int i = 0; i < 12; i++) begin
         rnd      = $random(seed);
         rnd2     = $random(seed);
         w        = rnd[29:20];
         words[i] = w;
         drive_write(MODE_36, {w, rnd[31:30]}, 2'b11, rnd[17:0], '0, 2'b11, rnd2[17:0]);
         mem_h1[w] = rnd[17:0];    // low 18 bits
         mem_h2[w] = rnd2[17:0];   // high 18 bits
      end
      end_write();
      for (int i = 0; i < 12; i++) begin
         rnd = $random(seed);
         drive_read(MODE_36, {words[i], rnd[1:0]}, '0);
         compare(rdata_b1_o, mem_h1[words[i]], $sformatf("36-bit low word %0d", words[i]));
         compare(rdata_b2_o, mem_h2[words[i]], $sformatf("36-bit high word %0d", words[i]));
      end
      report_test("combined 36-bit", err0);
   endtask

   task automatic test_narrow();
      logic [31:0]        rnd;
      logic [HALF_AW-1:0] w;
      logic [1:0]         sel;
      logic [2:0]         mode;
      logic [HALF_DW-1:0] word;
      int                 err0;
      err0 = errors;
      for (int i = 0; i < 16; i++) begin
         rnd  = $random(seed);
         w    = words[int'(rnd[23:20]) % 12];
         sel  = rnd[25:24];   // half, lane
         mode = (i % 2 == 1) ? MODE_9 : MODE_18;
         word = sel[1] ? mem_h2[w] : mem_h1[w];
         if (mode == MODE_18) begin
            word = merge_lanes(word, rnd[27:26], rnd[17:0]);
         end else if (sel[0]) begin
            word[HALF_DW-1:LANE_DW] = rnd[8:0];
         end else begin
            word[LANE_DW-1:0] = rnd[8:0];
         end
         if (sel[1]) begin
            mem_h2[w] = word;
         end else begin
            mem_h1[w] = word;
         end
         drive_write(mode, {w, sel}, rnd[27:26], rnd[17:0], '0, 2'b00, '0);
         end_write();
         drive_read(mode, {w, sel}, '0);
         if (mode == MODE_18) begin
            compare(rdata_b1_o, word, $sformatf("18-bit word %0d sel %0d", w, sel));
         end else begin
            compare(rdata_b1_o, {{LANE_DW{1'b0}}, (sel[0] ? word[17:9] : word[8:0])},
                    $sformatf("9-bit word %0d sel %0d", w, sel));
         end
         compare(rdata_b2_o, '0, "narrow read B2");
         drive_read(MODE_36, {w, 2'b00}, '0);   // other half and lane untouched
         compare(rdata_b1_o, mem_h1[w], "narrow write, half 1");
         compare(rdata_b2_o, mem_h2[w], "narrow write, half 2");
      end
      report_test("combined 18/9-bit", err0);
   endtask

   task automatic test_fifo();
      logic [31:0] rnd;
      int          err0;
      err0 = errors;
      set_mode(1'b0, 1'b1);
      @(negedge sclk_a1);
      check_flags("fifo state from reset");
      flush_fifo();
      check_flags("fifo after flush");
      for (int r = 0; r < 6; r++) begin
         rnd = $random(seed);
         push_burst(1 + int'(rnd[3:0]));
         check_flags($sformatf("flags after push round %0d", r));
         pop_burst(1 + int'(rnd[15:8]) % fifo_q.size());
         check_flags($sformatf("flags after pop round %0d", r));
      end
      pop_burst(fifo_q.size());
      check_flags("fifo drained");
      report_test("fifo order and flags", err0);
   endtask

   task automatic test_flags();
      int err0;
      err0 = errors;
      flush_fifo();
      push_burst(FIFO_DEPTH - AF_LEVEL - 1);
      check_flags("below almost full");
      push_burst(1);
      check_flags("at almost full");
      push_burst(AF_LEVEL);
      check_flags("fifo full");
      push_burst(3);
      check_flags("overrun");
      pop_burst(FIFO_DEPTH);
      check_flags("drained after overrun");
      pop_burst(1);
      check_flags("underrun");
      flush_fifo();
      check_flags("flush clears flags");
      report_test("overrun and underrun", err0);
   endtask

   initial begin
      #(BUDGET * 2 * 10);
      $display("watchdog: the run timed out before all tests finished");
      $display("Test failed");
      $finish;
   end

   initial begin
      sresetn = 1'b0;
      {split_i, fmode_i} = 2'b10;
      {wmode_a1_i, rmode_b1_i} = {MODE_36, MODE_36};
      {wen_a1_i, wen_a2_i, ren_b1_i, ren_b2_i, flush_i} = '0;
      {addr_a1_i, addr_b1_i, addr_a2_i, addr_b2_i} = '0;
      {be_a1_i, be_a2_i, wdata_a1_i, wdata_a2_i} = '0;
      upae_i = FIFO_AW'(AE_LEVEL);
      upaf_i = FIFO_AW'(AF_LEVEL);
      {ur_flag, ovr_flag} = 2'b00;
      repeat (5) @(posedge sclk_a1);
      sresetn <= 1'b1;
      @(negedge sclk_a1);
      test_split();
      test_wide();
      test_narrow();
      test_fifo();
      test_flags();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- verilog/tdp36k.sv
`timescale 1ns/1ps

module tdp36k (
   input  logic                         sclk_a1,
   input  logic                         sresetn,
   input  logic                         split_i,
   input  logic                         fmode_i,
   input  logic [2:0]                   wmode_a1_i,
   input  logic [2:0]                   rmode_b1_i,
   input  logic                         wen_a1_i,
   input  logic [1:0]                   be_a1_i,
   input  logic [bram_pkg::COMB_AW-1:0] addr_a1_i,
   input  logic [bram_pkg::HALF_DW-1:0] wdata_a1_i,
   input  logic                         wen_a2_i,
   input  logic [1:0]                   be_a2_i,
   input  logic [bram_pkg::HALF_AW-1:0] addr_a2_i,
   input  logic [bram_pkg::HALF_DW-1:0] wdata_a2_i,
   input  logic                         ren_b1_i,
   input  logic [bram_pkg::COMB_AW-1:0] addr_b1_i,
   input  logic                         ren_b2_i,
   input  logic [bram_pkg::HALF_AW-1:0] addr_b2_i,
   input  logic                         flush_i,
   input  logic [bram_pkg::FIFO_AW-1:0] upae_i,
   input  logic [bram_pkg::FIFO_AW-1:0] upaf_i,
   output logic [bram_pkg::HALF_DW-1:0] rdata_b1_o,
   output logic [bram_pkg::HALF_DW-1:0] rdata_b2_o
);
   import bram_pkg::*;

   logic               push;
   logic               pop;
   logic [FIFO_AW-1:0] fifo_waddr;
   logic [FIFO_AW-1:0] fifo_raddr;
   fifo_status_t       fifo_status;
   logic               h1_wen;
   logic               h2_wen;
   logic [1:0]         h1_be;
   logic [1:0]         h2_be;
   logic [HALF_AW-1:0] h1_waddr;
   logic [HALF_AW-1:0] h2_waddr;
   logic [HALF_DW-1:0] h1_wdata;
   logic [HALF_DW-1:0] h2_wdata;
   logic               h1_ren;
   logic               h2_ren;
   logic [HALF_AW-1:0] h1_raddr;
   logic [HALF_AW-1:0] h2_raddr;
   logic [HALF_DW-1:0] h1_rdata;
   logic [HALF_DW-1:0] h2_rdata;
   logic [1:0]         rd_sel;
   logic               rd_take;

   fifo_ctl u_fifo (
      .sclk_a1, .sresetn,
      .enable_i (fmode_i & ~split_i),   // FIFO only in combined mode
      .flush_i, .wen_i (wen_a1_i), .ren_i (ren_b1_i),
      .upae_i, .upaf_i,
      .push_o (push), .pop_o (pop),
      .waddr_o (fifo_waddr), .raddr_o (fifo_raddr),
      .status_o (fifo_status)
   );

   port_steer u_steer (
      .split_i, .fmode_i, .wmode_a1_i, .rmode_b1_i,
      .wen_a1_i, .be_a1_i, .addr_a1_i, .wdata_a1_i,
      .wen_a2_i, .be_a2_i, .addr_a2_i, .wdata_a2_i,
      .ren_b1_i, .addr_b1_i, .ren_b2_i, .addr_b2_i,
      .push_i (push), .pop_i (pop), .waddr_i (fifo_waddr), .raddr_i (fifo_raddr),
      .wen_h1_o (h1_wen), .be_h1_o (h1_be), .waddr_h1_o (h1_waddr),
      .wdata_h1_o (h1_wdata), .ren_h1_o (h1_ren), .raddr_h1_o (h1_raddr),
      .wen_h2_o (h2_wen), .be_h2_o (h2_be), .waddr_h2_o (h2_waddr),
      .wdata_h2_o (h2_wdata), .ren_h2_o (h2_ren), .raddr_h2_o (h2_raddr),
      .rd_sel_o (rd_sel), .rd_take_o (rd_take)
   );

   ram_half u_half1 (
      .sclk_a1, .sresetn,
      .wen_i (h1_wen), .be_i (h1_be), .waddr_i (h1_waddr), .wdata_i (h1_wdata),
      .ren_i (h1_ren), .raddr_i (h1_raddr), .rdata_o (h1_rdata)
   );

   ram_half u_half2 (
      .sclk_a1, .sresetn,
      .wen_i (h2_wen), .be_i (h2_be), .waddr_i (h2_waddr), .wdata_i (h2_wdata),
      .ren_i (h2_ren), .raddr_i (h2_raddr), .rdata_o (h2_rdata)
   );

   read_steer u_read (
      .sclk_a1, .sresetn, .split_i, .fmode_i, .rmode_b1_i,
      .rd_sel_i (rd_sel), .rd_take_i (rd_take),
      .rdata_h1_i (h1_rdata), .rdata_h2_i (h2_rdata),
      .status_i (fifo_status),
      .rdata_b1_o, .rdata_b2_o
   );

endmodule

//--- verilog/read_steer.sv
`timescale 1ns/1ps

module read_steer (
   input  logic                         sclk_a1,
   input  logic                         sresetn,
   input  logic                         split_i,
   input  logic                         fmode_i,
   input  logic [2:0]                   rmode_b1_i,
   input  logic [1:0]                   rd_sel_i,
   input  logic                         rd_take_i,
   input  logic [bram_pkg::HALF_DW-1:0] rdata_h1_i,
   input  logic [bram_pkg::HALF_DW-1:0] rdata_h2_i,
   input  bram_pkg::fifo_status_t       status_i,
   output logic [bram_pkg::HALF_DW-1:0] rdata_b1_o,
   output logic [bram_pkg::HALF_DW-1:0] rdata_b2_o
);
   import bram_pkg::*;

   logic [1:0]         rd_sel_q;    // half and lane of the last read
   logic               fifo_mode;
   logic [HALF_DW-1:0] half_word;
   logic [LANE_DW-1:0] lane_word;
   rd_word_u           b2_word;

   assign fifo_mode = ~split_i & fmode_i;
   assign half_word = rd_sel_q[1] ? rdata_h2_i : rdata_h1_i;
   assign lane_word = rd_sel_q[0] ? half_word[HALF_DW-1:LANE_DW] : half_word[LANE_DW-1:0];

   // loads with the RAM read register
   always_ff @(posedge sclk_a1 or negedge sresetn) begin
      if (!sresetn) begin
         rd_sel_q <= '0;
      end else if (rd_take_i) begin
         rd_sel_q <= rd_sel_i;
      end
   end

   always_comb begin
      rdata_b1_o   = half_word;
      b2_word.data = '0;
      if (split_i) begin
         rdata_b1_o   = rdata_h1_i;
         b2_word.data = rdata_h2_i;
      end else if (fifo_mode) begin
         b2_word.status = status_i;   // flags instead of data
      end else begin
         case (width_code(rmode_b1_i))
            MODE_9:  rdata_b1_o = HALF_DW'(lane_word);   // zero-extended byte
            MODE_18: rdata_b1_o = half_word;
            default: begin
               rdata_b1_o   = rdata_h1_i;
               b2_word.data = rdata_h2_i;
            end
         endcase
      end
   end

   assign rdata_b2_o = b2_word.data;

   // FIFO data holds on B1 until the next pop
   a_fifo_hold: assert property (@(posedge sclk_a1) disable iff (!sresetn)
      (fifo_mode && !rd_take_i) ##1 fifo_mode |-> $stable(rdata_b1_o))
      else $error("fifo read data changed without a pop");

endmodule

//--- verilog/port_steer.sv
`timescale 1ns/1ps

module port_steer (
   input  logic                         split_i,
   input  logic                         fmode_i,
   input  logic [2:0]                   wmode_a1_i,
   input  logic [2:0]                   rmode_b1_i,
   input  logic                         wen_a1_i,
   input  logic [1:0]                   be_a1_i,
   input  logic [bram_pkg::COMB_AW-1:0] addr_a1_i,
   input  logic [bram_pkg::HALF_DW-1:0] wdata_a1_i,
   input  logic                         wen_a2_i,
   input  logic [1:0]                   be_a2_i,
   input  logic [bram_pkg::HALF_AW-1:0] addr_a2_i,
   input  logic [bram_pkg::HALF_DW-1:0] wdata_a2_i,
   input  logic                         ren_b1_i,
   input  logic [bram_pkg::COMB_AW-1:0] addr_b1_i,
   input  logic                         ren_b2_i,
   input  logic [bram_pkg::HALF_AW-1:0] addr_b2_i,
   input  logic                         push_i,
   input  logic                         pop_i,
   input  logic [bram_pkg::FIFO_AW-1:0] waddr_i,
   input  logic [bram_pkg::FIFO_AW-1:0] raddr_i,
   output logic                         wen_h1_o,
   output logic [1:0]                   be_h1_o,
   output logic [bram_pkg::HALF_AW-1:0] waddr_h1_o,
   output logic [bram_pkg::HALF_DW-1:0] wdata_h1_o,
   output logic                         ren_h1_o,
   output logic [bram_pkg::HALF_AW-1:0] raddr_h1_o,
   output logic                         wen_h2_o,
   output logic [1:0]                   be_h2_o,
   output logic [bram_pkg::HALF_AW-1:0] waddr_h2_o,
   output logic [bram_pkg::HALF_DW-1:0] wdata_h2_o,
   output logic                         ren_h2_o,
   output logic [bram_pkg::HALF_AW-1:0] raddr_h2_o,
   output logic [1:0]                   rd_sel_o,
   output logic                         rd_take_o
);
   import bram_pkg::*;

   logic       fifo_mode;
   logic [2:0] wmode;
   logic [2:0] rmode;

   assign fifo_mode = ~split_i & fmode_i;
   assign wmode     = width_code(wmode_a1_i);
   assign rmode     = width_code(rmode_b1_i);

   // write side
   always_comb begin
      wen_h1_o   = wen_a1_i;
      wen_h2_o   = wen_a1_i;
      be_h1_o    = be_a1_i;
      be_h2_o    = be_a1_i;
      waddr_h1_o = addr_a1_i[COMB_AW-1:2];
      waddr_h2_o = addr_a1_i[COMB_AW-1:2];
      wdata_h1_o = wdata_a1_i;
      wdata_h2_o = wdata_a1_i;
      if (split_i) begin
         waddr_h1_o = addr_a1_i[HALF_AW-1:0];   // low word bits only
         wen_h2_o   = wen_a2_i;
         be_h2_o    = be_a2_i;
         waddr_h2_o = addr_a2_i;
         wdata_h2_o = wdata_a2_i;
      end else if (fifo_mode) begin
         wen_h1_o   = push_i & ~waddr_i[0];   // entries alternate halves
         wen_h2_o   = push_i & waddr_i[0];
         be_h1_o    = 2'b11;
         be_h2_o    = 2'b11;
         waddr_h1_o = waddr_i[FIFO_AW-1:1];
         waddr_h2_o = waddr_i[FIFO_AW-1:1];
      end else if (wmode != MODE_36) begin
         wen_h1_o = wen_a1_i & ~addr_a1_i[1];
         wen_h2_o = wen_a1_i & addr_a1_i[1];
         if (wmode == MODE_9) begin
            be_h1_o    = 2'b01 << addr_a1_i[0];
            be_h2_o    = 2'b01 << addr_a1_i[0];
            wdata_h1_o = {2{wdata_a1_i[LANE_DW-1:0]}};   // same byte on both lanes
            wdata_h2_o = {2{wdata_a1_i[LANE_DW-1:0]}};
         end
      end else begin
         be_h2_o    = be_a2_i;
         wdata_h2_o = wdata_a2_i;   // upper 18 bits of the 36-bit word
      end
   end

   // read side
   always_comb begin
      ren_h1_o   = ren_b1_i;
      ren_h2_o   = ren_b1_i;
      raddr_h1_o = addr_b1_i[COMB_AW-1:2];
      raddr_h2_o = addr_b1_i[COMB_AW-1:2];
      rd_sel_o   = addr_b1_i[1:0];
      rd_take_o  = ren_b1_i;
      if (split_i) begin
         raddr_h1_o = addr_b1_i[HALF_AW-1:0];
         ren_h2_o   = ren_b2_i;
         raddr_h2_o = addr_b2_i;
      end else if (fifo_mode) begin
         ren_h1_o   = pop_i & ~raddr_i[0];
         ren_h2_o   = pop_i & raddr_i[0];
         raddr_h1_o = raddr_i[FIFO_AW-1:1];
         raddr_h2_o = raddr_i[FIFO_AW-1:1];
         rd_sel_o   = {raddr_i[0], 1'b0};
         rd_take_o  = pop_i;   // underrun leaves the output alone
      end else if (rmode != MODE_36) begin
         ren_h1_o = ren_b1_i & ~addr_b1_i[1];   // only the addressed half
         ren_h2_o = ren_b1_i & addr_b1_i[1];
      end
   end

endmodule

//--- verilog/fifo_ctl.sv
`timescale 1ns/1ps

module fifo_ctl (
   input  logic                         sclk_a1,
   input  logic                         sresetn,
   input  logic                         enable_i,
   input  logic                         flush_i,
   input  logic                         wen_i,
   input  logic                         ren_i,
   input  logic [bram_pkg::FIFO_AW-1:0] upae_i,
   input  logic [bram_pkg::FIFO_AW-1:0] upaf_i,
   output logic                         push_o,
   output logic                         pop_o,
   output logic [bram_pkg::FIFO_AW-1:0] waddr_o,
   output logic [bram_pkg::FIFO_AW-1:0] raddr_o,
   output bram_pkg::fifo_status_t       status_o
);
   import bram_pkg::*;

   logic [CNT_W-1:0] count;      // entries held
   logic [CNT_W-1:0] af_level;   // almost-full threshold
   logic             empty;
   logic             full;
   logic             underrun;
   logic             overrun;

   assign empty    = (count == '0);
   assign full     = (count == CNT_W'(FIFO_DEPTH));
   assign af_level = CNT_W'(FIFO_DEPTH) - CNT_W'(upaf_i);

   // flush wins over a strobe in the same cycle
   assign push_o = enable_i & ~flush_i & wen_i & ~full;
   assign pop_o  = enable_i & ~flush_i & ren_i & ~empty;

   always_ff @(posedge sclk_a1 or negedge sresetn) begin
      if (!sresetn) begin
         waddr_o <= '0;
         raddr_o <= '0;
         count   <= '0;
      end else if (flush_i) begin
         waddr_o <= '0;
         raddr_o <= '0;
         count   <= '0;
      end else begin
         if (push_o) begin
            waddr_o <= waddr_o + 1'b1;   // wraps at depth
         end
         if (pop_o) begin
            raddr_o <= raddr_o + 1'b1;
         end
         count <= count + CNT_W'(push_o) - CNT_W'(pop_o);
      end
   end

   // sticky error flags, cleared only by flush or reset
   always_ff @(posedge sclk_a1 or negedge sresetn) begin
      if (!sresetn) begin
         overrun  <= 1'b0;
         underrun <= 1'b0;
      end else if (flush_i) begin
         overrun  <= 1'b0;
         underrun <= 1'b0;
      end else begin
         if (enable_i && wen_i && full) begin
            overrun <= 1'b1;   // write dropped
         end
         if (enable_i && ren_i && empty) begin
            underrun <= 1'b1;
         end
      end
   end

   always_comb begin
      status_o              = '0;
      status_o.empty        = empty;
      status_o.almost_empty = (count <= CNT_W'(upae_i));
      status_o.underrun     = underrun;
      status_o.full         = full;
      status_o.almost_full  = (count >= af_level);
      status_o.overrun      = overrun;
   end

   a_count_max: assert property (@(posedge sclk_a1) disable iff (!sresetn)
      count <= CNT_W'(FIFO_DEPTH))
      else $error("fifo count above depth");

   // pointer distance tracks the fill count, modulo depth
   a_ptr_count: assert property (@(posedge sclk_a1) disable iff (!sresetn)
      count[FIFO_AW-1:0] == FIFO_AW'(waddr_o - raddr_o))
      else $error("fifo count disagrees with pointer distance");

endmodule

//--- verilog/ram_half.sv
`timescale 1ns/1ps

module ram_half (
   input  logic                         sclk_a1,
   input  logic                         sresetn,
   input  logic                         wen_i,
   input  logic [1:0]                   be_i,
   input  logic [bram_pkg::HALF_AW-1:0] waddr_i,
   input  logic [bram_pkg::HALF_DW-1:0] wdata_i,
   input  logic                         ren_i,
   input  logic [bram_pkg::HALF_AW-1:0] raddr_i,
   output logic [bram_pkg::HALF_DW-1:0] rdata_o
);
   import bram_pkg::*;

   logic [HALF_DW-1:0] mem [0:2**HALF_AW-1];   // 1024 x 18

   // write port, each 9-bit lane has its own enable
   always_ff @(posedge sclk_a1) begin
      for (int l = 0; l < HALF_DW / LANE_DW; l++) begin
         if (wen_i && be_i[l]) begin
            mem[waddr_i][l*LANE_DW +: LANE_DW] <= wdata_i[l*LANE_DW +: LANE_DW];
         end
      end
   end

   // read register holds between reads
   always_ff @(posedge sclk_a1 or negedge sresetn) begin
      if (!sresetn) begin
         rdata_o <= '0;
      end else if (ren_i) begin
         rdata_o <= mem[raddr_i];   // old data on a same-address write
      end
   end

   a_waddr_known: assert property (@(posedge sclk_a1) disable iff (!sresetn)
      wen_i |-> !$isunknown(waddr_i))
      else $error("write address unknown while write enable is high");

endmodule

//--- verilog/bram_pkg.sv
package bram_pkg;

   localparam int HALF_AW    = 10;   // word address of one 18K half
   localparam int HALF_DW    = 18;
   localparam int LANE_DW    = 9;    // one byte lane with its ninth bit
   localparam int COMB_AW    = 12;   // word, half, lane
   localparam int FIFO_AW    = 11;   // bit 0 picks the half
   localparam int FIFO_DEPTH = 2048;
   localparam int CNT_W      = 12;   // holds 0 to FIFO_DEPTH

   // width codes on wmode/rmode
   localparam logic [2:0] MODE_36 = 3'b011;
   localparam logic [2:0] MODE_18 = 3'b010;
   localparam logic [2:0] MODE_9  = 3'b001;

   typedef struct packed {
      logic [11:0] pad;
      logic        empty;
      logic        almost_empty;
      logic        underrun;
      logic        full;
      logic        almost_full;
      logic        overrun;
   } fifo_status_t;

   // port B2 read word, either RAM data or FIFO flags
   typedef union packed {
      logic [HALF_DW-1:0] data;
      fifo_status_t       status;
   } rd_word_u;

   // unknown codes fall back to the full 36-bit width
   function automatic logic [2:0] width_code(input logic [2:0] mode);
      if (mode == MODE_18 || mode == MODE_9) begin
         return mode;
      end
      return MODE_36;
   endfunction

endpackage
